//--- verilog/rf_ldst_pkg.sv
// Vector load/store shared definitions

package rf_ldst_pkg;

    // SDRAM byte address width
    parameter int SDRAM_ADDR_W = 32;

    ////////////////////////////////////////////////////////////
    // Engine states
    ////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        IDLE,         // Waiting for a start strobe
        LD_ADDR,      // Read request until accepted
        LD_BEATS,     // Collect read beats
        LD_RF_WRITE,  // Line buffer to RF row
        ST_RF_READ,   // RF row read request
        ST_RF_LATCH,  // RF row into line buffer
        ST_BEATS      // Write burst
    } ldst_state_t;

endpackage

//--- verilog/rf_ldst_intf.sv
// Load/store command bus
`timescale 1ns/10ps

interface rf_ldst_intf import rf_ldst_pkg::*; #(
    parameter int RF_ADDR_W  = 4,
    parameter int LINE_NUM_W = 4
);
    logic                    load_start;   // One-cycle strobe
    logic                    store_start;  // One-cycle strobe
    logic [SDRAM_ADDR_W-1:0] sdram_addr;
    logic [RF_ADDR_W-1:0]    rf_addr;
    logic [LINE_NUM_W-1:0]   line_num;
    logic                    rf_addr_inc;  // Step RF row per line

    modport engine (
        input load_start, store_start, sdram_addr, rf_addr, line_num, rf_addr_inc
    );
    modport ctrl (
        output load_start, store_start, sdram_addr, rf_addr, line_num, rf_addr_inc
    );
endinterface

//--- verilog/sdram_intf.sv
// Avalon-MM burst bus
`timescale 1ns/10ps

interface sdram_intf import rf_ldst_pkg::*; #(
    parameter int SDRAM_DATA_W = 32,
    parameter int RF_DATA_W    = 128
);
    localparam int BEATS   = RF_DATA_W / SDRAM_DATA_W;
    localparam int BURST_W = $clog2(BEATS + 1);
    localparam int BE_W    = SDRAM_DATA_W / 8;

    // Master side
    logic                    read;
    logic                    write;
    logic [SDRAM_ADDR_W-1:0] address;     // Byte address
    logic [BURST_W-1:0]      burstcount;
    logic [BE_W-1:0]         byteenable;
    logic [SDRAM_DATA_W-1:0] writedata;

    // Slave side
    logic [SDRAM_DATA_W-1:0] readdata;
    logic                    readdatavalid;
    logic                    waitrequest;

    modport master (
        output read, write, address, burstcount, byteenable, writedata,
        input  readdata, readdatavalid, waitrequest
    );
    modport slave (
        input  read, write, address, burstcount, byteenable, writedata,
        output readdata, readdatavalid, waitrequest
    );
endinterface

//--- verilog/bram_intf.sv
// Register-file RAM engine port
`timescale 1ns/10ps

interface bram_intf #(
    parameter int RF_ADDR_W = 4,
    parameter int RF_DATA_W = 128
);
    logic [RF_ADDR_W-1:0] addr;
    logic [RF_DATA_W-1:0] data;  // Write data
    logic                 we;
    logic                 re;
    logic [RF_DATA_W-1:0] q;     // Valid one cycle after re

    modport engine (
        output addr, data, we, re,
        input  q
    );
    modport memory (
        input  addr, data, we, re,
        output q
    );
endinterface

//--- verilog/rf_ldst.sv
// Vector load/store engine
`timescale 1ns/10ps

module rf_ldst import rf_ldst_pkg::*; #(
    parameter int RF_ADDR_W    = 4,
    parameter int LINE_NUM_W   = 4,
    parameter int SDRAM_DATA_W = 32,
    parameter int RF_DATA_W    = 128
) (
    input  logic        clk,
    input  logic        rst_n,
    rf_ldst_intf.engine cmd,     // Command from control unit
    sdram_intf.master   sdram,   // Avalon SDRAM
    bram_intf.engine    rf_ram,  // Register-file RAM
    output logic        done     // High while idle
);

    localparam int BEATS      = RF_DATA_W / SDRAM_DATA_W;
    localparam int BEAT_CNT_W = $clog2(BEATS + 1);  // Same as the burstcount width
    localparam int LINE_BYTES = RF_DATA_W / 8;

    ldst_state_t state;
    ldst_state_t state_nxt;

    logic cmd_ld;          // Capture command fields
    logic line_nxt;        // Step to next line
    logic line_last;
    logic beat_clr;
    logic beat_inc;
    logic buf_from_sdram;
    logic buf_from_rf;

    ////////////////////////////////////////////////////////////
    // Line and address counters
    ////////////////////////////////////////////////////////////
    logic [SDRAM_ADDR_W-1:0] sdram_addr;
    logic [RF_ADDR_W-1:0]    rf_addr;
    logic [LINE_NUM_W-1:0]   line_cnt;     // Lines left including the current one
    logic                    rf_addr_inc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sdram_addr  <= '0;
            rf_addr     <= '0;
            line_cnt    <= '0;
            rf_addr_inc <= 1'b0;
        end else if (cmd_ld) begin
            sdram_addr  <= cmd.sdram_addr;
            rf_addr     <= cmd.rf_addr;
            line_cnt    <= cmd.line_num;
            rf_addr_inc <= cmd.rf_addr_inc;
        end else if (line_nxt) begin
            sdram_addr <= sdram_addr + SDRAM_ADDR_W'(LINE_BYTES);
            line_cnt   <= line_cnt - 1'b1;
            if (rf_addr_inc) begin
                rf_addr <= rf_addr + 1'b1;
            end
        end
    end

    // A count of zero runs as a single line
    assign line_last = (line_cnt <= LINE_NUM_W'(1));

    ////////////////////////////////////////////////////////////
    // Line buffer and beat counter
    ////////////////////////////////////////////////////////////
    logic [BEAT_CNT_W-1:0]              beat_cnt;
    logic [BEATS-1:0][SDRAM_DATA_W-1:0] line_buf;  // Beat 0 in low bits

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (beat_clr) begin
            beat_cnt <= '0;
        end else if (beat_inc) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_from_rf) begin
            line_buf <= rf_ram.q;                    // Whole row at once
        end else if (buf_from_sdram) begin
            line_buf[beat_cnt] <= sdram.readdata;
        end
    end

    // Bus outputs
    assign sdram.address    = sdram_addr;
    assign sdram.burstcount = BEAT_CNT_W'(BEATS);   // Always a full line
    assign sdram.byteenable = '1;
    assign sdram.writedata  = line_buf[beat_cnt];

    assign rf_ram.addr = rf_addr;
    assign rf_ram.data = line_buf;

    assign done = (state == IDLE);

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt      = state;
        sdram.read     = 1'b0;
        sdram.write    = 1'b0;
        rf_ram.we      = 1'b0;
        rf_ram.re      = 1'b0;
        cmd_ld         = 1'b0;
        line_nxt       = 1'b0;
        beat_clr       = 1'b0;
        beat_inc       = 1'b0;
        buf_from_sdram = 1'b0;
        buf_from_rf    = 1'b0;

        case (state)
            IDLE: begin
                beat_clr = 1'b1;
                if (cmd.load_start) begin          // Load has priority
                    cmd_ld    = 1'b1;
                    state_nxt = LD_ADDR;
                end else if (cmd.store_start) begin
                    cmd_ld    = 1'b1;
                    state_nxt = ST_RF_READ;
                end
            end

            LD_ADDR: begin
                sdram.read = 1'b1;                 // Held until accepted
                if (!sdram.waitrequest) begin
                    state_nxt = LD_BEATS;
                end
            end

            LD_BEATS: begin
                if (sdram.readdatavalid) begin
                    buf_from_sdram = 1'b1;
                    beat_inc       = 1'b1;
                    if (beat_cnt == BEAT_CNT_W'(BEATS - 1)) begin
                        state_nxt = LD_RF_WRITE;
                    end
                end
            end

            LD_RF_WRITE: begin
                rf_ram.we = 1'b1;
                line_nxt  = 1'b1;
                beat_clr  = 1'b1;
                state_nxt = line_last ? IDLE : LD_ADDR;
            end

            ST_RF_READ: begin
                rf_ram.re = 1'b1;
                beat_clr  = 1'b1;
                state_nxt = ST_RF_LATCH;
            end

            ST_RF_LATCH: begin
                buf_from_rf = 1'b1;                // q is valid here
                state_nxt   = ST_BEATS;
            end

            ST_BEATS: begin
                sdram.write = 1'b1;
                // Only accepted beats move the burst on
                if (!sdram.waitrequest) begin
                    beat_inc = 1'b1;
                    if (beat_cnt == BEAT_CNT_W'(BEATS - 1)) begin
                        line_nxt  = 1'b1;
                        state_nxt = line_last ? IDLE : ST_RF_READ;
                    end
                end
            end

            default: state_nxt = IDLE;
        endcase
    end

endmodule

//--- verilog/rf_ram.sv
// Dual-port register-file RAM
`timescale 1ns/10ps

module rf_ram #(
    parameter int RF_ADDR_W = 4,
    parameter int RF_DATA_W = 128
) (
    input  logic                 clk,
    bram_intf.memory             port,        // Engine side
    input  logic [RF_ADDR_W-1:0] host_addr,
    input  logic [RF_DATA_W-1:0] host_wdata,
    input  logic                 host_we,
    output logic [RF_DATA_W-1:0] host_rdata
);

    localparam int ROWS = 2 ** RF_ADDR_W;

    logic [RF_DATA_W-1:0] mem [ROWS];

    // Engine port and host port on one array
    always_ff @(posedge clk) begin
        if (port.we) begin
            mem[port.addr] <= port.data;
        end
        if (port.re) begin
            port.q <= mem[port.addr];  // Registered engine read
        end

        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
        host_rdata <= mem[host_addr];  // Host reads every cycle
    end

endmodule

//--- verilog/vec_ldst_top.sv
// Vector load/store subsystem top
`timescale 1ns/10ps

module vec_ldst_top import rf_ldst_pkg::*; #(
    parameter int RF_ADDR_W    = 4,
    parameter int LINE_NUM_W   = 4,
    parameter int SDRAM_DATA_W = 32,
    parameter int RF_DATA_W    = 128
) (
    input  logic                                              clk,
    input  logic                                              rst_n,

    // Command
    input  logic                                              load_start,
    input  logic                                              store_start,
    input  logic [SDRAM_ADDR_W-1:0]                           sdram_addr,
    input  logic [RF_ADDR_W-1:0]                              rf_addr,
    input  logic [LINE_NUM_W-1:0]                             line_num,
    input  logic                                              rf_addr_inc,
    output logic                                              done,

    // Avalon-MM master
    output logic                                              read,
    output logic                                              write,
    output logic [SDRAM_ADDR_W-1:0]                           address,
    output logic [$clog2(RF_DATA_W / SDRAM_DATA_W + 1)-1:0]   burstcount,
    output logic [SDRAM_DATA_W/8-1:0]                         byteenable,
    output logic [SDRAM_DATA_W-1:0]                           writedata,
    input  logic [SDRAM_DATA_W-1:0]                           readdata,
    input  logic                                              readdatavalid,
    input  logic                                              waitrequest,

    // Host port of the register file
    input  logic [RF_ADDR_W-1:0]                              host_addr,
    input  logic [RF_DATA_W-1:0]                              host_wdata,
    input  logic                                              host_we,
    output logic [RF_DATA_W-1:0]                              host_rdata
);

    rf_ldst_intf #(.RF_ADDR_W(RF_ADDR_W), .LINE_NUM_W(LINE_NUM_W)) cmd_if ();
    sdram_intf #(.SDRAM_DATA_W(SDRAM_DATA_W), .RF_DATA_W(RF_DATA_W)) sdram_if ();
    bram_intf #(.RF_ADDR_W(RF_ADDR_W), .RF_DATA_W(RF_DATA_W)) bram_if ();

    ////////////////////////////////////////////////////////////
    // Plain ports to buses
    ////////////////////////////////////////////////////////////
    assign cmd_if.load_start  = load_start;
    assign cmd_if.store_start = store_start;
    assign cmd_if.sdram_addr  = sdram_addr;
    assign cmd_if.rf_addr     = rf_addr;
    assign cmd_if.line_num    = line_num;
    assign cmd_if.rf_addr_inc = rf_addr_inc;

    assign read       = sdram_if.read;
    assign write      = sdram_if.write;
    assign address    = sdram_if.address;
    assign burstcount = sdram_if.burstcount;
    assign byteenable = sdram_if.byteenable;
    assign writedata  = sdram_if.writedata;

    assign sdram_if.readdata      = readdata;
    assign sdram_if.readdatavalid = readdatavalid;
    assign sdram_if.waitrequest   = waitrequest;

    rf_ldst #(
        .RF_ADDR_W    (RF_ADDR_W),
        .LINE_NUM_W   (LINE_NUM_W),
        .SDRAM_DATA_W (SDRAM_DATA_W),
        .RF_DATA_W    (RF_DATA_W)
    ) u_rf_ldst (
        .clk    (clk),
        .rst_n  (rst_n),
        .cmd    (cmd_if.engine),
        .sdram  (sdram_if.master),
        .rf_ram (bram_if.engine),
        .done   (done)
    );

    rf_ram #(
        .RF_ADDR_W (RF_ADDR_W),
        .RF_DATA_W (RF_DATA_W)
    ) u_rf_ram (
        .clk        (clk),
        .port       (bram_if.memory),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_we    (host_we),
        .host_rdata (host_rdata)
    );

endmodule

//--- verif/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter real PERIOD_NS  = 8.0,
    parameter int  RST_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;  // Released away from the active edge
    end

endmodule

//--- verif/tb_vec_ldst.sv
// Vector load/store testbench
`timescale 1ns/10ps

module tb_vec_ldst import rf_ldst_pkg::*;;

    localparam int RF_ADDR_W      = 4;
    localparam int LINE_NUM_W     = 4;
    localparam int SDRAM_DATA_W   = 32;
    localparam int RF_DATA_W      = 128;
    localparam int BEATS          = RF_DATA_W / SDRAM_DATA_W;
    localparam int BURST_W        = $clog2(BEATS + 1);
    localparam int LINE_BYTES     = RF_DATA_W / 8;
    localparam int ROWS           = 2 ** RF_ADDR_W;
    localparam int SDRAM_WORDS    = 256;   // 1 KB model
    localparam int TIMEOUT_CYCLES = 4000;  // Well above the full sequence with stalls

    logic                        clk;
    logic                        rst_n;
    logic                        load_start;
    logic                        store_start;
    logic [SDRAM_ADDR_W-1:0]     sdram_addr;
    logic [RF_ADDR_W-1:0]        rf_addr;
    logic [LINE_NUM_W-1:0]       line_num;
    logic                        rf_addr_inc;
    logic                        done;
    logic                        read;
    logic                        write;
    logic [SDRAM_ADDR_W-1:0]     address;
    logic [BURST_W-1:0]          burstcount;
    logic [SDRAM_DATA_W/8-1:0]   byteenable;
    logic [SDRAM_DATA_W-1:0]     writedata;
    logic [SDRAM_DATA_W-1:0]     readdata      = '0;
    logic                        readdatavalid = 1'b0;
    logic                        waitrequest   = 1'b0;
    logic [RF_ADDR_W-1:0]        host_addr;
    logic [RF_DATA_W-1:0]        host_wdata;
    logic                        host_we;
    logic [RF_DATA_W-1:0]        host_rdata;

    logic [SDRAM_DATA_W-1:0] sdram_mem [SDRAM_WORDS];  // SDRAM model contents
    logic [SDRAM_DATA_W-1:0] exp_sdram [SDRAM_WORDS];  // Expected SDRAM
    logic [RF_DATA_W-1:0]    rf_model  [ROWS];         // Expected register file
    logic [15:0]             lfsr = 16'd62;
    bit                      stalls_on = 1'b0;
    int                      rd_left = 0;
    int                      rd_idx = 0;
    int                      wr_beat = 0;
    int                      burst_cnt = 0;            // Line bursts seen by the model
    int                      cycles = 0;
    ldst_state_t             eng_state;

    tb_clk_gen #(.PERIOD_NS(8.0), .RST_CYCLES(5)) clk_gen0 (.clk(clk), .rst_n(rst_n));

    vec_ldst_top #(
        .RF_ADDR_W    (RF_ADDR_W),
        .LINE_NUM_W   (LINE_NUM_W),
        .SDRAM_DATA_W (SDRAM_DATA_W),
        .RF_DATA_W    (RF_DATA_W)
    ) dut0 (.*);

    assign eng_state = dut0.u_rf_ldst.state;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic rand_bit();
        lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        return lfsr[0];
    endfunction

    function automatic logic [RF_DATA_W-1:0] rand_bits();
        logic [RF_DATA_W-1:0] v;
        for (int i = 0; i < RF_DATA_W; i++) begin
            v[i] = rand_bit();
        end
        return v;
    endfunction

    function automatic int word_index(logic [SDRAM_ADDR_W-1:0] byte_addr, int beat);
        return (int'(byte_addr >> 2) + beat) % SDRAM_WORDS;
    endfunction

    // Expected state after a command with beat 0 in the low bits of a row
    function automatic void ref_cmd(bit is_load, logic [SDRAM_ADDR_W-1:0] addr, int row,
                                    int num, bit inc);
        int lines;
        int r;
        int w;
        lines = (num == 0) ? 1 : num;
        for (int i = 0; i < lines; i++) begin
            r = (row + (inc ? i : 0)) % ROWS;
            for (int b = 0; b < BEATS; b++) begin
                w = word_index(addr + SDRAM_ADDR_W'(i * LINE_BYTES), b);
                if (is_load) begin
                    rf_model[r][b*SDRAM_DATA_W +: SDRAM_DATA_W] = exp_sdram[w];
                end else begin
                    exp_sdram[w] = rf_model[r][b*SDRAM_DATA_W +: SDRAM_DATA_W];
                end
            end
        end
    endfunction

    task automatic stop_with(string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compare_line(logic [RF_DATA_W-1:0] got, logic [RF_DATA_W-1:0] exp, int row);
        if (got !== exp) begin
            stop_with($sformatf("FAIL %0t: RF row %0d is %h, expected %h", $time, row, got, exp));
        end
    endtask

    task automatic compare_beat(logic [SDRAM_DATA_W-1:0] got, logic [SDRAM_DATA_W-1:0] exp,
                                int byte_addr);
        if (got !== exp) begin
            stop_with($sformatf("FAIL %0t: SDRAM address %h is %h, expected %h",
                                $time, byte_addr, got, exp));
        end
    endtask

    task automatic check_level(logic got, logic exp, string what);
        if (got !== exp) begin
            stop_with($sformatf("FAIL %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic write_row(int row, logic [RF_DATA_W-1:0] data);
        @(negedge clk);
        host_addr  = RF_ADDR_W'(row);
        host_wdata = data;
        host_we    = 1'b1;
        @(negedge clk);
        host_we    = 1'b0;
    endtask

    task automatic read_row(int row, output logic [RF_DATA_W-1:0] data);
        @(negedge clk);
        host_addr = RF_ADDR_W'(row);
        @(negedge clk);
        data = host_rdata;  // Registered read lands one cycle later
    endtask

    task automatic check_contents();
        logic [RF_DATA_W-1:0] row_data;
        for (int r = 0; r < ROWS; r++) begin
            read_row(r, row_data);
            compare_line(row_data, rf_model[r], r);
        end
        for (int w = 0; w < SDRAM_WORDS; w++) begin
            compare_beat(sdram_mem[w], exp_sdram[w], w * 4);
        end
    endtask

    task automatic run_cmd(bit is_load, logic [SDRAM_ADDR_W-1:0] addr, int row, int num,
                           bit inc);
        int lines;
        lines = (num == 0) ? 1 : num;
        @(negedge clk);
        check_level(done, 1'b1, "done before start");
        burst_cnt   = 0;
        sdram_addr  = addr;
        rf_addr     = RF_ADDR_W'(row);
        line_num    = LINE_NUM_W'(num);
        rf_addr_inc = inc;
        load_start  = is_load;
        store_start = !is_load;
        @(negedge clk);
        load_start  = 1'b0;
        store_start = 1'b0;
        check_level(done, 1'b0, "done after start");
        while (!done) begin
            @(negedge clk);
        end
        if (burst_cnt != lines) begin
            stop_with($sformatf("FAIL %0t: done rose after %0d of %0d line bursts",
                                $time, burst_cnt, lines));
        end
        ref_cmd(is_load, addr, row, num, inc);
        check_contents();
    endtask

    ////////////////////////////////////////////////////////////
    // SDRAM model driven on the falling edge
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst_n) begin
            readdatavalid = 1'b0;
            if (rd_left > 0 && (!stalls_on || rand_bit())) begin
                readdatavalid = 1'b1;
                readdata      = sdram_mem[rd_idx];
                rd_idx        = (rd_idx + 1) % SDRAM_WORDS;
                rd_left--;
            end
            waitrequest = (read || write) && stalls_on && rand_bit();
            if ((read || write) && !waitrequest) begin  // Accepted on the next rising edge
                if (burstcount !== BURST_W'(BEATS)) begin
                    stop_with($sformatf("FAIL %0t: burstcount %0d", $time, burstcount));
                end
                if (byteenable !== '1) begin
                    stop_with($sformatf("FAIL %0t: byteenable %b", $time, byteenable));
                end
            end
            if (read && !waitrequest) begin
                rd_idx  = word_index(address, 0);
                rd_left = BEATS;
                burst_cnt++;
            end
            if (write && !waitrequest) begin
                sdram_mem[word_index(address, wr_beat)] = writedata;
                wr_beat++;
                if (wr_beat == BEATS) begin
                    wr_beat = 0;
                    burst_cnt++;
                end
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            stop_with($sformatf("Run timed out after %0d cycles with the engine in state %s",
                                cycles, eng_state.name()));
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    initial begin
        load_start  = 1'b0;
        store_start = 1'b0;
        sdram_addr  = '0;
        rf_addr     = '0;
        line_num    = '0;
        rf_addr_inc = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        host_we     = 1'b0;
        wait (rst_n === 1'b1);

        repeat (6) begin  // Quiet bus while idle
            @(negedge clk);
            check_level(done, 1'b1, "done after reset");
            check_level(read, 1'b0, "read after reset");
            check_level(write, 1'b0, "write after reset");
        end

        for (int w = 0; w < SDRAM_WORDS; w++) begin
            sdram_mem[w] = rand_bits();
            exp_sdram[w] = sdram_mem[w];
        end
        for (int r = 0; r < ROWS; r++) begin
            rf_model[r] = rand_bits();
            write_row(r, rf_model[r]);
        end

        // No stalls
        run_cmd(1'b1, 32'h040, 3, 1, 1'b1);
        run_cmd(1'b1, 32'h100, 5, 3, 1'b1);
        run_cmd(1'b1, 32'h200, 9, 3, 1'b0);   // Last line stays in row 9
        run_cmd(1'b0, 32'h300, 0, 4, 1'b1);

        // Random waitrequest and readdatavalid gaps
        stalls_on = 1'b1;
        run_cmd(1'b1, 32'h080, 10, 5, 1'b1);
        run_cmd(1'b0, 32'h380, 1, 3, 1'b1);
        run_cmd(1'b1, 32'h0c0, 15, 0, 1'b1);  // Zero count runs one line
        run_cmd(1'b0, 32'h3c0, 7, 2, 1'b0);

        // Round trip from 0x000 through rows 0..3 to 0x200
        run_cmd(1'b1, 32'h000, 0, 4, 1'b1);
        run_cmd(1'b0, 32'h200, 0, 4, 1'b1);
        for (int k = 0; k < 4 * BEATS; k++) begin
            compare_beat(sdram_mem[128 + k], sdram_mem[k], 32'h200 + 4 * k);
        end

        $display("Test OK");
        $finish;
    end

endmodule

//--- src.f
verilog/rf_ldst_pkg.sv
verilog/rf_ldst_intf.sv
verilog/sdram_intf.sv
verilog/bram_intf.sv
verilog/rf_ldst.sv
verilog/rf_ram.sv
verilog/vec_ldst_top.sv
verif/tb_clk_gen.sv
verif/tb_vec_ldst.sv

//--- Bender.yml
package:
  name: vec_ldst

sources:
  - verilog/rf_ldst_pkg.sv
  - verilog/rf_ldst_intf.sv
  - verilog/sdram_intf.sv
  - verilog/bram_intf.sv
  - verilog/rf_ldst.sv
  - verilog/rf_ram.sv
  - verilog/vec_ldst_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_vec_ldst.sv
